/* design/glb_bank_pkg.sv */
/*
 * global buffer bank package
 * widths, depth and read latency shared by the bank controller and memory,
 * plus vector types for addresses, words and configuration data
 */
package glb_bank_pkg;

    // byte address into one bank
    localparam int BANK_ADDR_WIDTH = 10;
    // one sram word
    localparam int BANK_DATA_WIDTH = 64;
    // config port moves half a word
    localparam int CFG_DATA_WIDTH = 32;
    // byte offset bits below the word index
    localparam int BANK_BYTE_OFFSET = 3;
    // word index width, address above the byte offset
    localparam int BANK_WORD_IDX_WIDTH = BANK_ADDR_WIDTH - BANK_BYTE_OFFSET;
    // memory depth in words
    localparam int BANK_WORDS = 128;
    // request to data, in cycles
    localparam int SRAM_RD_LATENCY = 3;

    // byte address
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
    // word data, also the per-bit write mask
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
    // half word on the config side
    typedef logic [CFG_DATA_WIDTH-1:0] cfg_data_t;
    // word index into the array
    typedef logic [BANK_WORD_IDX_WIDTH-1:0] bank_word_idx_t;

endpackage

/* design/glb_bank_sram.sv */
/*
 * global buffer bank memory
 * single-port word array with a per-bit write mask and a three stage
 * registered read path standing in for the macro latency
 */
`timescale 1ns/1ps

module glb_bank_sram (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_rd_en,
    input  logic                     mem_wr_en,
    input  glb_bank_pkg::bank_addr_t mem_addr,
    input  glb_bank_pkg::bank_data_t mem_data_in,
    input  glb_bank_pkg::bank_data_t mem_data_in_bit_sel,
    output glb_bank_pkg::bank_data_t mem_data_out
);

    import glb_bank_pkg::*;

    // word storage
    bank_data_t     mem [BANK_WORDS];

    // word index, byte offset dropped
    bank_word_idx_t word_idx;

    // read pipeline stages
    bank_data_t     rd_stage1;
    bank_data_t     rd_stage2;
    bank_data_t     rd_stage3;

    assign word_idx = mem_addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];

    // masked write, only bits with a set mask change
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[word_idx] <= (mem[word_idx] & ~mem_data_in_bit_sel)
                           | (mem_data_in & mem_data_in_bit_sel);
        end
    end

    // first stage samples the array on a read
    // later stages just shift
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_stage1 <= '0;
            rd_stage2 <= '0;
            rd_stage3 <= '0;
        end else begin
            if (mem_rd_en) begin
                rd_stage1 <= mem[word_idx];
            end
            rd_stage2 <= rd_stage1;
            rd_stage3 <= rd_stage2;
        end
    end

    // data lands SRAM_RD_LATENCY edges after the request
    assign mem_data_out = rd_stage3;

endmodule

/* design/glb_bank_ctrl.sv */
/*
 * global buffer bank controller
 * fixed priority arbiter between the config and packet requesters in
 * front of one single-port sram, with half-word lane steering for config
 * writes and delayed tracking of read returns
 */
`timescale 1ns/1ps

module glb_bank_ctrl (
    input  logic                     clk,
    input  logic                     reset,

    // packet requester
    input  logic                     packet_wr_en,
    input  glb_bank_pkg::bank_addr_t packet_wr_addr,
    input  glb_bank_pkg::bank_data_t packet_wr_data,
    input  glb_bank_pkg::bank_data_t packet_wr_data_bit_sel,
    input  logic                     packet_rd_en,
    input  glb_bank_pkg::bank_addr_t packet_rd_addr,
    output glb_bank_pkg::bank_data_t packet_rd_data,
    output logic                     packet_rd_data_valid,

    // config requester
    input  logic                     cfg_wr_en,
    input  glb_bank_pkg::bank_addr_t cfg_wr_addr,
    input  glb_bank_pkg::cfg_data_t  cfg_wr_data,
    input  logic                     cfg_rd_en,
    input  glb_bank_pkg::bank_addr_t cfg_rd_addr,
    output glb_bank_pkg::cfg_data_t  cfg_rd_data,
    output logic                     cfg_rd_data_valid,

    // memory side
    output logic                     mem_rd_en,
    output logic                     mem_wr_en,
    output glb_bank_pkg::bank_addr_t mem_addr,
    output glb_bank_pkg::bank_data_t mem_data_in,
    output glb_bank_pkg::bank_data_t mem_data_in_bit_sel,
    input  glb_bank_pkg::bank_data_t mem_data_out
);

    import glb_bank_pkg::*;

    // one grant per cycle, losers are dropped
    logic       cfg_wr_grant;
    logic       cfg_rd_grant;
    logic       pkt_wr_grant;
    logic       pkt_rd_grant;

    // config write lane steering
    logic       cfg_wr_half;
    bank_data_t cfg_wr_data_lane;
    bank_data_t cfg_wr_mask_lane;

    // read return tracking, bit 0 is the newest stage
    logic [SRAM_RD_LATENCY-1:0] pkt_rd_pipe;
    logic [SRAM_RD_LATENCY-1:0] cfg_rd_pipe;
    logic [SRAM_RD_LATENCY-1:0] cfg_half_pipe;
    logic       pkt_rd_ret;
    logic       cfg_rd_ret;
    logic       cfg_half_ret;
    cfg_data_t  cfg_rd_half_data;

    // last returned values, shown between valid pulses
    bank_data_t packet_rd_data_q;
    cfg_data_t  cfg_rd_data_q;

    // priority: cfg write, cfg read, packet write, packet read
    assign cfg_wr_grant = cfg_wr_en;
    assign cfg_rd_grant = cfg_rd_en & ~cfg_wr_en;
    assign pkt_wr_grant = packet_wr_en & ~cfg_wr_en & ~cfg_rd_en;
    assign pkt_rd_grant = packet_rd_en & ~cfg_wr_en & ~cfg_rd_en & ~packet_wr_en;

    // bit 2 of the byte address picks the half
    assign cfg_wr_half = cfg_wr_addr[BANK_BYTE_OFFSET-1];

    always_comb begin
        if (cfg_wr_half) begin
            // upper half, data and mask shifted up
            cfg_wr_data_lane = {cfg_wr_data, {(BANK_DATA_WIDTH-CFG_DATA_WIDTH){1'b0}}};
            cfg_wr_mask_lane = {{CFG_DATA_WIDTH{1'b1}}, {(BANK_DATA_WIDTH-CFG_DATA_WIDTH){1'b0}}};
        end else begin
            cfg_wr_data_lane = {{(BANK_DATA_WIDTH-CFG_DATA_WIDTH){1'b0}}, cfg_wr_data};
            cfg_wr_mask_lane = {{(BANK_DATA_WIDTH-CFG_DATA_WIDTH){1'b0}}, {CFG_DATA_WIDTH{1'b1}}};
        end
    end

    // memory request mux
    always_comb begin
        mem_rd_en           = 1'b0;
        mem_wr_en           = 1'b0;
        mem_addr            = '0;
        mem_data_in         = '0;
        mem_data_in_bit_sel = '0;
        if (cfg_wr_grant) begin
            mem_wr_en           = 1'b1;
            mem_addr            = cfg_wr_addr;
            mem_data_in         = cfg_wr_data_lane;
            mem_data_in_bit_sel = cfg_wr_mask_lane;
        end else if (cfg_rd_grant) begin
            mem_rd_en = 1'b1;
            mem_addr  = cfg_rd_addr;
        end else if (pkt_wr_grant) begin
            mem_wr_en           = 1'b1;
            mem_addr            = packet_wr_addr;
            mem_data_in         = packet_wr_data;
            mem_data_in_bit_sel = packet_wr_data_bit_sel;
        end else if (pkt_rd_grant) begin
            mem_rd_en = 1'b1;
            mem_addr  = packet_rd_addr;
        end
    end

    // follow granted reads down the sram latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_rd_pipe   <= '0;
            cfg_rd_pipe   <= '0;
            cfg_half_pipe <= '0;
        end else begin
            pkt_rd_pipe   <= {pkt_rd_pipe[SRAM_RD_LATENCY-2:0], pkt_rd_grant};
            cfg_rd_pipe   <= {cfg_rd_pipe[SRAM_RD_LATENCY-2:0], cfg_rd_grant};
            // half select rides along with the config read
            cfg_half_pipe <= {cfg_half_pipe[SRAM_RD_LATENCY-2:0],
                              cfg_rd_addr[BANK_BYTE_OFFSET-1]};
        end
    end

    assign pkt_rd_ret   = pkt_rd_pipe[SRAM_RD_LATENCY-1];
    assign cfg_rd_ret   = cfg_rd_pipe[SRAM_RD_LATENCY-1];
    assign cfg_half_ret = cfg_half_pipe[SRAM_RD_LATENCY-1];

    // pick the returning half for the config port
    assign cfg_rd_half_data = cfg_half_ret ? mem_data_out[CFG_DATA_WIDTH +: CFG_DATA_WIDTH]
                                           : mem_data_out[0 +: CFG_DATA_WIDTH];

    // hold registers, zero out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_rd_data_q <= '0;
            cfg_rd_data_q    <= '0;
        end else begin
            packet_rd_data_q <= packet_rd_data;
            cfg_rd_data_q    <= cfg_rd_data;
        end
    end

    // fresh data on return, else last value
    assign packet_rd_data       = pkt_rd_ret ? mem_data_out : packet_rd_data_q;
    assign packet_rd_data_valid = pkt_rd_ret;
    assign cfg_rd_data          = cfg_rd_ret ? cfg_rd_half_data : cfg_rd_data_q;
    assign cfg_rd_data_valid    = cfg_rd_ret;

endmodule

/* design/glb_bank.sv */
/*
 * global buffer bank
 * one bank controller arbitrating the packet and config requesters
 * in front of a single-port sram
 */
`timescale 1ns/1ps

module glb_bank (
    input  logic                     clk,
    input  logic                     reset,

    // packet side
    input  logic                     packet_wr_en,
    input  glb_bank_pkg::bank_addr_t packet_wr_addr,
    input  glb_bank_pkg::bank_data_t packet_wr_data,
    input  glb_bank_pkg::bank_data_t packet_wr_data_bit_sel,
    input  logic                     packet_rd_en,
    input  glb_bank_pkg::bank_addr_t packet_rd_addr,
    output glb_bank_pkg::bank_data_t packet_rd_data,
    output logic                     packet_rd_data_valid,

    // config side
    input  logic                     cfg_wr_en,
    input  glb_bank_pkg::bank_addr_t cfg_wr_addr,
    input  glb_bank_pkg::cfg_data_t  cfg_wr_data,
    input  logic                     cfg_rd_en,
    input  glb_bank_pkg::bank_addr_t cfg_rd_addr,
    output glb_bank_pkg::cfg_data_t  cfg_rd_data,
    output logic                     cfg_rd_data_valid
);

    import glb_bank_pkg::*;

    // controller to memory
    logic       mem_rd_en;
    logic       mem_wr_en;
    bank_addr_t mem_addr;
    bank_data_t mem_data_in;
    bank_data_t mem_data_in_bit_sel;
    bank_data_t mem_data_out;

    // arbiter and return tracking
    glb_bank_ctrl u_ctrl (
        .clk                    (clk),
        .reset                  (reset),
        .packet_wr_en           (packet_wr_en),
        .packet_wr_addr         (packet_wr_addr),
        .packet_wr_data         (packet_wr_data),
        .packet_wr_data_bit_sel (packet_wr_data_bit_sel),
        .packet_rd_en           (packet_rd_en),
        .packet_rd_addr         (packet_rd_addr),
        .packet_rd_data         (packet_rd_data),
        .packet_rd_data_valid   (packet_rd_data_valid),
        .cfg_wr_en              (cfg_wr_en),
        .cfg_wr_addr            (cfg_wr_addr),
        .cfg_wr_data            (cfg_wr_data),
        .cfg_rd_en              (cfg_rd_en),
        .cfg_rd_addr            (cfg_rd_addr),
        .cfg_rd_data            (cfg_rd_data),
        .cfg_rd_data_valid      (cfg_rd_data_valid),
        .mem_rd_en              (mem_rd_en),
        .mem_wr_en              (mem_wr_en),
        .mem_addr               (mem_addr),
        .mem_data_in            (mem_data_in),
        .mem_data_in_bit_sel    (mem_data_in_bit_sel),
        .mem_data_out           (mem_data_out)
    );

    // single-port word memory
    glb_bank_sram u_sram (
        .clk                 (clk),
        .reset               (reset),
        .mem_rd_en           (mem_rd_en),
        .mem_wr_en           (mem_wr_en),
        .mem_addr            (mem_addr),
        .mem_data_in         (mem_data_in),
        .mem_data_in_bit_sel (mem_data_in_bit_sel),
        .mem_data_out        (mem_data_out)
    );

endmodule

/* tests/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * 20 ns clock, reset held high for the first three cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lands on a falling edge
    initial begin
        reset = 1'b1;
        #(PERIOD * RESET_CYCLES);
        reset = 1'b0;
    end

endmodule

/* tests/glb_bank_assert.sv */
/*
 * bound checks on the bank controller
 * memory port exclusivity, config read return timing, one valid per cycle
 */
`timescale 1ns/1ps

module glb_bank_assert (
    input logic clk,
    input logic reset,
    input logic mem_rd_en,
    input logic mem_wr_en,
    input logic cfg_wr_en,
    input logic cfg_rd_en,
    input logic cfg_rd_data_valid,
    input logic packet_rd_data_valid
);

    import glb_bank_pkg::*;

    // failures seen so far, read by the testbench at the end
    int assert_errors = 0;

    // single-port memory, never read and write together
    a_mem_one_op: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_en && mem_wr_en))
    else begin
        assert_errors++;
        $error("memory read and write enabled in the same cycle");
    end

    // granted config read comes back after the sram latency
    a_cfg_rd_return: assert property (@(posedge clk) disable iff (reset)
        (cfg_rd_en && !cfg_wr_en) |-> ##SRAM_RD_LATENCY cfg_rd_data_valid)
    else begin
        assert_errors++;
        $error("granted config read gave no cfg_rd_data_valid");
    end

    // only one read type can return per cycle
    a_one_valid: assert property (@(posedge clk) disable iff (reset)
        !(cfg_rd_data_valid && packet_rd_data_valid))
    else begin
        assert_errors++;
        $error("packet and config read valids high together");
    end

endmodule

bind glb_bank_ctrl glb_bank_assert u_assert (.*);

/* tests/tb_glb_bank.sv */
/*
 * testbench for the global buffer bank
 * one table row of requests per cycle, a reference memory predicts
 * every read, results checked when they return three cycles later
 */
`timescale 1ns/1ps

module tb_glb_bank;

    import glb_bank_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_ROWS   = 64;

    // which port should return data for a row
    localparam logic [1:0] EXP_NONE = 2'd0;
    localparam logic [1:0] EXP_PKT  = 2'd1;
    localparam logic [1:0] EXP_CFG  = 2'd2;

    typedef struct packed {
        logic       pkt_wr;
        bank_addr_t pkt_wr_addr;
        bank_data_t pkt_wr_data;
        bank_data_t pkt_wr_mask;
        logic       pkt_rd;
        bank_addr_t pkt_rd_addr;
        logic       cfg_wr;
        bank_addr_t cfg_wr_addr;
        cfg_data_t  cfg_wr_data;
        logic       cfg_rd;
        bank_addr_t cfg_rd_addr;
        logic [1:0] exp_port;
    } row_t;

    logic       clk;
    logic       reset;
    logic       packet_wr_en;
    bank_addr_t packet_wr_addr;
    bank_data_t packet_wr_data;
    bank_data_t packet_wr_data_bit_sel;
    logic       packet_rd_en;
    bank_addr_t packet_rd_addr;
    bank_data_t packet_rd_data;
    logic       packet_rd_data_valid;
    logic       cfg_wr_en;
    bank_addr_t cfg_wr_addr;
    cfg_data_t  cfg_wr_data;
    logic       cfg_rd_en;
    bank_addr_t cfg_rd_addr;
    cfg_data_t  cfg_rd_data;
    logic       cfg_rd_data_valid;

    // stimulus table and the row being built
    row_t       rows [MAX_ROWS];
    row_t       cur;
    int         num_rows;
    integer     seed;
    logic       table_ready;

    // reference memory and predictions waiting for their cycle
    bank_data_t ref_mem [BANK_WORDS];
    logic       exp_pkt_valid_q [$];
    bank_data_t exp_pkt_data_q [$];
    logic       exp_cfg_valid_q [$];
    cfg_data_t  exp_cfg_data_q [$];
    bank_data_t last_pkt;
    cfg_data_t  last_cfg;
    int         error_count;
    int         check_count;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    glb_bank u_glb_bank (
        .clk                    (clk),
        .reset                  (reset),
        .packet_wr_en           (packet_wr_en),
        .packet_wr_addr         (packet_wr_addr),
        .packet_wr_data         (packet_wr_data),
        .packet_wr_data_bit_sel (packet_wr_data_bit_sel),
        .packet_rd_en           (packet_rd_en),
        .packet_rd_addr         (packet_rd_addr),
        .packet_rd_data         (packet_rd_data),
        .packet_rd_data_valid   (packet_rd_data_valid),
        .cfg_wr_en              (cfg_wr_en),
        .cfg_wr_addr            (cfg_wr_addr),
        .cfg_wr_data            (cfg_wr_data),
        .cfg_rd_en              (cfg_rd_en),
        .cfg_rd_addr            (cfg_rd_addr),
        .cfg_rd_data            (cfg_rd_data),
        .cfg_rd_data_valid      (cfg_rd_data_valid)
    );

    function automatic bank_data_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic cfg_data_t rand32();
        return $random(seed);
    endfunction

    function automatic int word_of(input bank_addr_t addr);
        return int'(addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]);
    endfunction

    // several strobes may share one row
    task automatic set_pkt_wr(input bank_addr_t addr, input bank_data_t data,
                              input bank_data_t mask);
        cur.pkt_wr      = 1'b1;
        cur.pkt_wr_addr = addr;
        cur.pkt_wr_data = data;
        cur.pkt_wr_mask = mask;
    endtask

    task automatic set_pkt_rd(input bank_addr_t addr);
        cur.pkt_rd      = 1'b1;
        cur.pkt_rd_addr = addr;
    endtask

    task automatic set_cfg_wr(input bank_addr_t addr, input cfg_data_t data);
        cur.cfg_wr      = 1'b1;
        cur.cfg_wr_addr = addr;
        cur.cfg_wr_data = data;
    endtask

    task automatic set_cfg_rd(input bank_addr_t addr);
        cur.cfg_rd      = 1'b1;
        cur.cfg_rd_addr = addr;
    endtask

    task automatic commit_row(input logic [1:0] exp_port);
        cur.exp_port   = exp_port;
        rows[num_rows] = cur;
        num_rows++;
        cur = '0;
    endtask

    task automatic build_table();
        seed     = 32'h89616fd1;
        num_rows = 0;
        cur      = '0;
        // full word write then read back
        set_pkt_wr(10'h008, rand64(), '1);
        commit_row(EXP_NONE);
        set_pkt_rd(10'h008);
        commit_row(EXP_PKT);
        // partial mask over a known word
        set_pkt_wr(10'h010, rand64(), '1);
        commit_row(EXP_NONE);
        set_pkt_wr(10'h010, rand64(), rand64());
        commit_row(EXP_NONE);
        set_pkt_rd(10'h010);
        commit_row(EXP_PKT);
        // bit 2 picks the low or high config half
        set_cfg_wr(10'h020, rand32());
        commit_row(EXP_NONE);
        set_cfg_wr(10'h024, rand32());
        commit_row(EXP_NONE);
        set_cfg_rd(10'h020);
        commit_row(EXP_CFG);
        set_cfg_rd(10'h024);
        commit_row(EXP_CFG);
        set_pkt_rd(10'h020);
        commit_row(EXP_PKT);
        // known contents for the words that collisions target
        set_pkt_wr(10'h038, rand64(), '1);
        commit_row(EXP_NONE);
        set_pkt_wr(10'h040, rand64(), '1);
        commit_row(EXP_NONE);
        // cfg write beats packet write and packet read
        set_cfg_wr(10'h030, rand32());
        set_pkt_wr(10'h038, rand64(), '1);
        set_pkt_rd(10'h008);
        commit_row(EXP_NONE);
        // cfg read beats packet read
        set_cfg_rd(10'h030);
        set_pkt_rd(10'h008);
        commit_row(EXP_CFG);
        // cfg read beats packet write
        set_cfg_rd(10'h020);
        set_pkt_wr(10'h040, rand64(), '1);
        commit_row(EXP_CFG);
        // packet write beats packet read
        set_pkt_wr(10'h010, rand64(), rand64());
        set_pkt_rd(10'h020);
        commit_row(EXP_NONE);
        // dropped writes left no trace
        set_pkt_rd(10'h038);
        commit_row(EXP_PKT);
        set_pkt_rd(10'h040);
        commit_row(EXP_PKT);
        // back to back reads then idle rows for the hold
        set_pkt_rd(10'h008);
        commit_row(EXP_PKT);
        set_pkt_rd(10'h010);
        commit_row(EXP_PKT);
        set_pkt_rd(10'h020);
        commit_row(EXP_PKT);
        commit_row(EXP_NONE);
        commit_row(EXP_NONE);
    endtask

    task automatic drive_row(input row_t r);
        packet_wr_en           = r.pkt_wr;
        packet_wr_addr         = r.pkt_wr_addr;
        packet_wr_data         = r.pkt_wr_data;
        packet_wr_data_bit_sel = r.pkt_wr_mask;
        packet_rd_en           = r.pkt_rd;
        packet_rd_addr         = r.pkt_rd_addr;
        cfg_wr_en              = r.cfg_wr;
        cfg_wr_addr            = r.cfg_wr_addr;
        cfg_wr_data            = r.cfg_wr_data;
        cfg_rd_en              = r.cfg_rd;
        cfg_rd_addr            = r.cfg_rd_addr;
    endtask

    // reference model with one winner per row
    task automatic predict(input row_t r);
        bank_data_t word;
        int         idx;
        int         bit_idx;
        word = '0;
        if (r.cfg_wr) begin
            idx = word_of(r.cfg_wr_addr);
            if (r.cfg_wr_addr[BANK_BYTE_OFFSET-1]) begin
                ref_mem[idx][CFG_DATA_WIDTH +: CFG_DATA_WIDTH] = r.cfg_wr_data;
            end else begin
                ref_mem[idx][0 +: CFG_DATA_WIDTH] = r.cfg_wr_data;
            end
        end else if (r.cfg_rd) begin
            word = ref_mem[word_of(r.cfg_rd_addr)];
        end else if (r.pkt_wr) begin
            idx = word_of(r.pkt_wr_addr);
            // only bits with a set mask take the new data
            for (bit_idx = 0; bit_idx < BANK_DATA_WIDTH; bit_idx++) begin
                if (r.pkt_wr_mask[bit_idx]) begin
                    ref_mem[idx][bit_idx] = r.pkt_wr_data[bit_idx];
                end
            end
        end else if (r.pkt_rd) begin
            word = ref_mem[word_of(r.pkt_rd_addr)];
        end
        exp_pkt_valid_q.push_back(r.exp_port == EXP_PKT);
        exp_pkt_data_q.push_back(word);
        exp_cfg_valid_q.push_back(r.exp_port == EXP_CFG);
        exp_cfg_data_q.push_back(r.cfg_rd_addr[BANK_BYTE_OFFSET-1] ?
                                 word[CFG_DATA_WIDTH +: CFG_DATA_WIDTH] :
                                 word[0 +: CFG_DATA_WIDTH]);
    endtask

    // compare this cycle's outputs with the prediction made three rows ago
    task automatic check_outputs();
        logic       pv;
        logic       cv;
        bank_data_t pd;
        cfg_data_t  cd;
        pv = exp_pkt_valid_q.pop_front();
        pd = exp_pkt_data_q.pop_front();
        cv = exp_cfg_valid_q.pop_front();
        cd = exp_cfg_data_q.pop_front();
        // outputs keep the last returned value between pulses
        if (pv) begin
            last_pkt = pd;
        end
        if (cv) begin
            last_cfg = cd;
        end
        check_count++;
        if (packet_rd_data_valid !== pv) begin
            $display("Error at time %0t: packet_rd_data_valid is %b, expected %b",
                     $time, packet_rd_data_valid, pv);
            error_count++;
        end
        if (packet_rd_data !== last_pkt) begin
            $display("Error at time %0t: packet_rd_data is %h, expected %h",
                     $time, packet_rd_data, last_pkt);
            error_count++;
        end
        if (cfg_rd_data_valid !== cv) begin
            $display("Error at time %0t: cfg_rd_data_valid is %b, expected %b",
                     $time, cfg_rd_data_valid, cv);
            error_count++;
        end
        if (cfg_rd_data !== last_cfg) begin
            $display("Error at time %0t: cfg_rd_data is %h, expected %h",
                     $time, cfg_rd_data, last_cfg);
            error_count++;
        end
    endtask

    initial begin
        row_t r;
        error_count = 0;
        check_count = 0;
        last_pkt    = '0;
        last_cfg    = '0;
        table_ready = 1'b0;
        drive_row('0);
        build_table();
        table_ready = 1'b1;
        // first cycles after reset expect no valid and zero data
        repeat (SRAM_RD_LATENCY) predict('0);
        @(negedge reset);
        @(posedge clk);
        for (int i = 0; i < num_rows + SRAM_RD_LATENCY; i++) begin
            @(negedge clk);
            check_outputs();
            if (i < num_rows) begin
                r = rows[i];
            end else begin
                r = '0;
            end
            drive_row(r);
            predict(r);
        end
        error_count += u_glb_bank.u_ctrl.u_assert.assert_errors;
        $display("rows: %0d, checks: %0d, errors: %0d", num_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // limit scales with the table length
    initial begin
        wait (table_ready);
        #((num_rows + 20) * CLK_PERIOD);
        $display("Timeout: the table did not finish within %0d cycles", num_rows + 20);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* compile.f */
design/glb_bank_pkg.sv
design/glb_bank_sram.sv
design/glb_bank_ctrl.sv
design/glb_bank.sv
tests/tb_clock_gen.sv
tests/glb_bank_assert.sv
tests/tb_glb_bank.sv

/* Makefile */
# Verilator flow for the global buffer bank
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_glb_bank
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

# static checks on the whole source list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# compile the testbench and design into one executable
build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# run, keep the log, decide pass or fail from the log
sim: build
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
